// ==== dual_cam_defines.svh ====
`ifndef DUAL_CAM_DEFINES_SVH
`define DUAL_CAM_DEFINES_SVH

// Frame geometry, width must be even for the side-by-side split
`define DC_FRAME_WIDTH    8
`define DC_FRAME_HEIGHT   4

// Bus and pixel widths
`define DC_BUS_WIDTH      32
`define DC_ADDR_WIDTH     32
`define DC_PIX_WIDTH      24

// FIFO sizing, prog_full leaves room for words already in flight
`define DC_FIFO_DEPTH     16
`define DC_FIFO_PROG_FULL 12

// Register word addresses, decoded from address bits 5:2
`define DC_REG_START      4'd0
`define DC_REG_ID         4'd4
`define DC_REG_STATUS     4'd5
`define DC_REG_CNT_IN1    4'd6
`define DC_REG_CNT_IN2    4'd7
`define DC_REG_CNT_OUT    4'd8

`define DC_ID_VALUE       32'hABCD_1234

`endif

// ==== dual_cam_pkg.sv ====
`include "dual_cam_defines.svh"

package dual_cam_pkg;

   // One RGB888 pixel
   typedef logic [`DC_PIX_WIDTH-1:0] pixel_t;

   // Merged output beat, frame_end marks the last pixel of a frame
   typedef struct packed {
      logic   frame_end;
      pixel_t pix;
   } merged_beat_t;

   // One word on a DMA read stream
   typedef struct packed {
      logic [`DC_BUS_WIDTH-1:0]   data;
      logic [`DC_BUS_WIDTH/8-1:0] keep;
   } dma_rd_stream_t;

   // Error pulses from one FIFO
   typedef struct packed {
      logic overflow;
      logic underflow;
   } fifo_events_t;

   // Everything the register bank counts or latches
   typedef struct packed {
      logic         in1_push;
      logic         in2_push;
      logic         out_pop;
      fifo_events_t in1_fifo;
      fifo_events_t in2_fifo;
      fifo_events_t out_fifo;
   } dbg_events_t;

endpackage

// ==== pix_fifo.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module pix_fifo #(
   parameter type payload_t = dual_cam_pkg::pixel_t,
   parameter int  DEPTH     = `DC_FIFO_DEPTH
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      push_i,
   input  payload_t                  data_i,
   input  logic                      pop_i,
   output payload_t                  data_o,
   output logic                      empty_o,
   output logic                      prog_full_o,
   output dual_cam_pkg::fifo_events_t events_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_nxt;
   logic             full;
   logic             do_push;
   logic             do_pop;
   logic             prog_full_q;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);
   assign do_push = push_i && !full;
   assign do_pop  = pop_i && !empty_o;

   // Show-ahead read side
   assign data_o      = mem[rd_ptr];
   assign prog_full_o = prog_full_q;

   // Bad operations are flagged and otherwise ignored
   assign events_o.overflow  = push_i && full;
   assign events_o.underflow = pop_i && empty_o;

   always_comb begin
      count_nxt = count;
      if (do_push && !do_pop) begin
         count_nxt = count + 1'b1;
      end else if (do_pop && !do_push) begin
         count_nxt = count - 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         prog_full_q <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count       <= count_nxt;
         prog_full_q <= (count_nxt >= CNT_W'(`DC_FIFO_PROG_FULL));
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

// ==== dma_stream_rx.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module dma_stream_rx (
   input  logic                         clk,
   input  logic                         rst,
   input  dual_cam_pkg::dma_rd_stream_t rd_i,
   input  logic                         rvalid_i,
   output logic                         rready_o,
   input  logic                         in_prog_full_i,
   input  logic                         out_prog_full_i,
   output logic                         push_o,
   output dual_cam_pkg::pixel_t         pixel_o
);

   logic                 rready_q;
   logic                 push_q;
   dual_cam_pkg::pixel_t pixel_q;

   // Stop taking words once either FIFO on the path nears full
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rready_q <= 1'b0;
         push_q   <= 1'b0;
      end else begin
         rready_q <= !in_prog_full_i && !out_prog_full_i;
         // Partial words are dropped
         push_q   <= rvalid_i && rready_q && (&rd_i.keep);
      end
   end

   always_ff @(posedge clk) begin
      pixel_q <= rd_i.data[`DC_PIX_WIDTH-1:0];
   end

   assign rready_o = rready_q;
   assign push_o   = push_q;
   assign pixel_o  = pixel_q;

endmodule

// ==== dual_cam_merger.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module dual_cam_merger (
   input  logic                       clk,
   input  logic                       rst,
   input  dual_cam_pkg::pixel_t       pix1_i,
   input  dual_cam_pkg::pixel_t       pix2_i,
   input  logic                       empty1_i,
   input  logic                       empty2_i,
   input  logic                       out_prog_full_i,
   output logic                       pop_o,
   output dual_cam_pkg::merged_beat_t beat_o,
   output logic                       beat_valid_o
);

   localparam int COL_W = $clog2(`DC_FRAME_WIDTH);
   localparam int ROW_W = $clog2(`DC_FRAME_HEIGHT);
   localparam int HALF  = `DC_FRAME_WIDTH / 2;

   logic [COL_W-1:0]           col;
   logic [ROW_W-1:0]           row;
   logic                       pop;
   logic                       last_col;
   logic                       last_row;
   logic                       beat_valid_q;
   dual_cam_pkg::merged_beat_t beat_q;

   // Both cameras advance together, stalled by output back-pressure
   assign pop      = !empty1_i && !empty2_i && !out_prog_full_i;
   assign last_col = (col == COL_W'(`DC_FRAME_WIDTH - 1));
   assign last_row = (row == ROW_W'(`DC_FRAME_HEIGHT - 1));

   //////////////////////////////////////////////////////////////////////
   // Frame position
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         col          <= '0;
         row          <= '0;
         beat_valid_q <= 1'b0;
      end else begin
         beat_valid_q <= pop;
         if (pop) begin
            col <= last_col ? '0 : col + 1'b1;
            if (last_col) begin
               row <= last_row ? '0 : row + 1'b1;
            end
         end
      end
   end

   // Left half from camera 1, right half from camera 2
   always_ff @(posedge clk) begin
      if (pop) begin
         beat_q.pix       <= (col < COL_W'(HALF)) ? pix1_i : pix2_i;
         beat_q.frame_end <= last_col && last_row;
      end
   end

   assign pop_o        = pop;
   assign beat_o       = beat_q;
   assign beat_valid_o = beat_valid_q;

endmodule

// ==== dma_frame_writer.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module dma_frame_writer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start_i,
   input  dual_cam_pkg::merged_beat_t beat_i,
   input  logic                       empty_i,
   output logic                       pop_o,
   input  logic                       dma_wready_i,
   output logic                       dma_wvalid_o,
   output logic                       dma_wlast_o,
   output logic [`DC_BUS_WIDTH-1:0]   dma_wdata_o,
   output logic                       frame_rst_o
);

   localparam int BEATS = `DC_FRAME_WIDTH * `DC_FRAME_HEIGHT;
   localparam int CNT_W = $clog2(BEATS);

   logic             start_q;
   logic             start_rise;
   logic             armed;
   logic [CNT_W-1:0] beat_cnt;
   logic             last;
   logic             wvalid;
   logic             xfer;
   logic             frame_rst_q;

   assign start_rise = start_i && !start_q;
   assign last       = (beat_cnt == CNT_W'(BEATS - 1));
   assign wvalid     = armed && !empty_i;
   assign xfer       = wvalid && dma_wready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_q     <= 1'b0;
         armed       <= 1'b0;
         beat_cnt    <= '0;
         frame_rst_q <= 1'b0;
      end else begin
         start_q <= start_i;
         if (start_rise) begin
            armed <= 1'b1;
         end else if (xfer && last) begin
            armed <= 1'b0;
         end
         if (xfer) begin
            beat_cnt <= last ? '0 : beat_cnt + 1'b1;
         end
         // Clears FIFOs and merger once the frame's final pixel leaves
         frame_rst_q <= xfer && beat_i.frame_end;
      end
   end

   assign pop_o        = xfer;
   assign dma_wvalid_o = wvalid;
   assign dma_wlast_o  = wvalid && last;
   assign dma_wdata_o  = {{(`DC_BUS_WIDTH - `DC_PIX_WIDTH){1'b0}}, beat_i.pix};
   assign frame_rst_o  = frame_rst_q;

endmodule

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module ctrl_regs (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      reg_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0] reg_waddr_i,
   input  logic [`DC_BUS_WIDTH-1:0]  reg_wdata_i,
   input  logic                      reg_re_i,
   input  logic [`DC_ADDR_WIDTH-1:0] reg_raddr_i,
   output logic [`DC_BUS_WIDTH-1:0]  reg_rdata_o,
   output logic                      reg_rvalid_o,
   input  dual_cam_pkg::dbg_events_t events_i,
   output logic                      start_o
);

   logic                     start_q;
   logic                     re_q;
   logic                     re_rise;
   logic                     rvalid_q;
   logic [5:0]               sticky;
   logic [5:0]               sticky_set;
   logic [`DC_BUS_WIDTH-1:0] cnt_in1;
   logic [`DC_BUS_WIDTH-1:0] cnt_in2;
   logic [`DC_BUS_WIDTH-1:0] cnt_out;
   logic [`DC_BUS_WIDTH-1:0] rd_mux;
   logic [`DC_BUS_WIDTH-1:0] rdata_q;

   // Read enable may be held, only its leading edge counts
   assign re_rise = reg_re_i && !re_q;

   assign sticky_set = {events_i.in1_fifo.underflow, events_i.in1_fifo.overflow,
                        events_i.in2_fifo.underflow, events_i.in2_fifo.overflow,
                        events_i.out_fifo.underflow, events_i.out_fifo.overflow};

   //////////////////////////////////////////////////////////////////////
   // Control and debug state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_q  <= 1'b0;
         re_q     <= 1'b0;
         rvalid_q <= 1'b0;
         sticky   <= '0;
         cnt_in1  <= '0;
         cnt_in2  <= '0;
         cnt_out  <= '0;
      end else begin
         if (reg_we_i && (reg_waddr_i[5:2] == `DC_REG_START)) begin
            start_q <= reg_wdata_i[0];
         end
         re_q     <= reg_re_i;
         rvalid_q <= re_rise;
         sticky   <= sticky | sticky_set;
         if (events_i.in1_push) begin
            cnt_in1 <= cnt_in1 + 1'b1;
         end
         if (events_i.in2_push) begin
            cnt_in2 <= cnt_in2 + 1'b1;
         end
         if (events_i.out_pop) begin
            cnt_out <= cnt_out + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (reg_raddr_i[5:2])
         `DC_REG_ID:      rd_mux = `DC_ID_VALUE;
         `DC_REG_STATUS:  rd_mux = {{(`DC_BUS_WIDTH - 6){1'b0}}, sticky};
         `DC_REG_CNT_IN1: rd_mux = cnt_in1;
         `DC_REG_CNT_IN2: rd_mux = cnt_in2;
         `DC_REG_CNT_OUT: rd_mux = cnt_out;
         default:         rd_mux = '0;
      endcase
   end

   // Data is presented with rvalid and zero otherwise
   always_ff @(posedge clk) begin
      rdata_q <= re_rise ? rd_mux : '0;
   end

   assign reg_rdata_o  = rdata_q;
   assign reg_rvalid_o = rvalid_q;
   assign start_o      = start_q;

endmodule

// ==== dual_cam_accel_top.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module dual_cam_accel_top (
   input  logic                         clk,
   input  logic                         rst,
   // Register bus
   input  logic                         reg_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0]    reg_waddr_i,
   input  logic [`DC_BUS_WIDTH-1:0]     reg_wdata_i,
   input  logic                         reg_re_i,
   input  logic [`DC_ADDR_WIDTH-1:0]    reg_raddr_i,
   output logic [`DC_BUS_WIDTH-1:0]     reg_rdata_o,
   output logic                         reg_rvalid_o,
   // DMA read streams
   input  dual_cam_pkg::dma_rd_stream_t dma1_rd_i,
   input  logic                         dma1_rvalid_i,
   output logic                         dma1_rready_o,
   input  dual_cam_pkg::dma_rd_stream_t dma2_rd_i,
   input  logic                         dma2_rvalid_i,
   output logic                         dma2_rready_o,
   // DMA write stream
   input  logic                         dma_wready_i,
   output logic                         dma_wvalid_o,
   output logic                         dma_wlast_o,
   output logic [`DC_BUS_WIDTH-1:0]     dma_wdata_o
);

   logic                       soft_rst;
   logic                       frame_rst;
   logic                       start;
   logic                       push1;
   logic                       push2;
   dual_cam_pkg::pixel_t       pix1_in;
   dual_cam_pkg::pixel_t       pix2_in;
   dual_cam_pkg::pixel_t       pix1_out;
   dual_cam_pkg::pixel_t       pix2_out;
   logic                       empty1;
   logic                       empty2;
   logic                       empty_out;
   logic                       prog_full1;
   logic                       prog_full2;
   logic                       prog_full_out;
   logic                       merge_pop;
   logic                       beat_push;
   logic                       out_pop;
   dual_cam_pkg::merged_beat_t beat_in;
   dual_cam_pkg::merged_beat_t beat_out;
   dual_cam_pkg::fifo_events_t ev1;
   dual_cam_pkg::fifo_events_t ev2;
   dual_cam_pkg::fifo_events_t ev_out;
   dual_cam_pkg::dbg_events_t  dbg_events;

   // FIFOs and merger restart after every frame
   assign soft_rst = rst || frame_rst;

   assign dbg_events = '{in1_push: push1, in2_push: push2, out_pop: out_pop,
                         in1_fifo: ev1, in2_fifo: ev2, out_fifo: ev_out};

   //////////////////////////////////////////////////////////////////////
   // Camera inputs
   //////////////////////////////////////////////////////////////////////

   dma_stream_rx u_rx1 (
      .clk (clk), .rst (rst), .rd_i (dma1_rd_i), .rvalid_i (dma1_rvalid_i),
      .rready_o (dma1_rready_o), .in_prog_full_i (prog_full1),
      .out_prog_full_i (prog_full_out), .push_o (push1), .pixel_o (pix1_in)
   );

   dma_stream_rx u_rx2 (
      .clk (clk), .rst (rst), .rd_i (dma2_rd_i), .rvalid_i (dma2_rvalid_i),
      .rready_o (dma2_rready_o), .in_prog_full_i (prog_full2),
      .out_prog_full_i (prog_full_out), .push_o (push2), .pixel_o (pix2_in)
   );

   pix_fifo #(.payload_t (dual_cam_pkg::pixel_t)) u_in_fifo1 (
      .clk (clk), .rst (soft_rst), .push_i (push1), .data_i (pix1_in),
      .pop_i (merge_pop), .data_o (pix1_out), .empty_o (empty1),
      .prog_full_o (prog_full1), .events_o (ev1)
   );

   pix_fifo #(.payload_t (dual_cam_pkg::pixel_t)) u_in_fifo2 (
      .clk (clk), .rst (soft_rst), .push_i (push2), .data_i (pix2_in),
      .pop_i (merge_pop), .data_o (pix2_out), .empty_o (empty2),
      .prog_full_o (prog_full2), .events_o (ev2)
   );

   //////////////////////////////////////////////////////////////////////
   // Merge and output
   //////////////////////////////////////////////////////////////////////

   dual_cam_merger u_merger (
      .clk (clk), .rst (soft_rst), .pix1_i (pix1_out), .pix2_i (pix2_out),
      .empty1_i (empty1), .empty2_i (empty2), .out_prog_full_i (prog_full_out),
      .pop_o (merge_pop), .beat_o (beat_in), .beat_valid_o (beat_push)
   );

   pix_fifo #(.payload_t (dual_cam_pkg::merged_beat_t)) u_out_fifo (
      .clk (clk), .rst (soft_rst), .push_i (beat_push), .data_i (beat_in),
      .pop_i (out_pop), .data_o (beat_out), .empty_o (empty_out),
      .prog_full_o (prog_full_out), .events_o (ev_out)
   );

   dma_frame_writer u_writer (
      .clk (clk), .rst (rst), .start_i (start), .beat_i (beat_out),
      .empty_i (empty_out), .pop_o (out_pop), .dma_wready_i (dma_wready_i),
      .dma_wvalid_o (dma_wvalid_o), .dma_wlast_o (dma_wlast_o),
      .dma_wdata_o (dma_wdata_o), .frame_rst_o (frame_rst)
   );

   ctrl_regs u_regs (
      .clk (clk), .rst (rst), .reg_we_i (reg_we_i), .reg_waddr_i (reg_waddr_i),
      .reg_wdata_i (reg_wdata_i), .reg_re_i (reg_re_i), .reg_raddr_i (reg_raddr_i),
      .reg_rdata_o (reg_rdata_o), .reg_rvalid_o (reg_rvalid_o),
      .events_i (dbg_events), .start_o (start)
   );

endmodule

// ==== dual_cam_assertions.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module dual_cam_assertions (
   input logic                     clk,
   input logic                     rst,
   input logic                     wvalid_i,
   input logic                     wready_i,
   input logic                     wlast_i,
   input logic [`DC_BUS_WIDTH-1:0] wdata_i,
   input logic                     rvalid_i
);

   int unsigned fail_count = 0;

   // A stalled write beat keeps valid and data until it is taken
   wvalid_held: assert property (@(posedge clk) disable iff (rst)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
      else begin
         fail_count++;
         $error("wvalid or wdata changed while wready was low");
      end

   // The writer goes idle once the last beat of a frame is taken
   wlast_ends_frame: assert property (@(posedge clk) disable iff (rst)
      wvalid_i && wready_i && wlast_i |=> !wvalid_i)
      else begin
         fail_count++;
         $error("wvalid stayed high after the last beat of the frame");
      end

   // One pulse per read
   rvalid_pulse: assert property (@(posedge clk) disable iff (rst)
      rvalid_i |=> !rvalid_i)
      else begin
         fail_count++;
         $error("rvalid longer than one cycle");
      end

endmodule

bind dual_cam_accel_top dual_cam_assertions u_assert (
   .clk (clk), .rst (rst), .wvalid_i (dma_wvalid_o), .wready_i (dma_wready_i),
   .wlast_i (dma_wlast_o), .wdata_i (dma_wdata_o), .rvalid_i (reg_rvalid_o)
);

// ==== tb_dual_cam_accel.sv ====
`timescale 1ns/1ps
`include "dual_cam_defines.svh"

module tb_dual_cam_accel;

   localparam int FRAME_PIX = `DC_FRAME_WIDTH * `DC_FRAME_HEIGHT;
   localparam int HALF      = `DC_FRAME_WIDTH / 2;
   localparam int LIMIT     = 4000;

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         reg_we;
   logic [`DC_ADDR_WIDTH-1:0]    reg_waddr;
   logic [`DC_BUS_WIDTH-1:0]     reg_wdata;
   logic                         reg_re;
   logic [`DC_ADDR_WIDTH-1:0]    reg_raddr;
   logic [`DC_BUS_WIDTH-1:0]     reg_rdata;
   logic                         reg_rvalid;
   dual_cam_pkg::dma_rd_stream_t rd_word [2];
   logic                         rd_valid [2];
   logic                         dma1_rready;
   logic                         dma2_rready;
   logic                         dma_wready;
   logic                         dma_wvalid;
   logic                         dma_wlast;
   logic [`DC_BUS_WIDTH-1:0]     dma_wdata;

   // Reference model state
   dual_cam_pkg::pixel_t model_q1 [$];
   dual_cam_pkg::pixel_t model_q2 [$];
   int                   accepted [2];
   int                   out_total;

   always #10 clk = ~clk;

   dual_cam_accel_top dual_cam_accel_top_i (
      .clk (clk), .rst (rst), .reg_we_i (reg_we), .reg_waddr_i (reg_waddr),
      .reg_wdata_i (reg_wdata), .reg_re_i (reg_re), .reg_raddr_i (reg_raddr),
      .reg_rdata_o (reg_rdata), .reg_rvalid_o (reg_rvalid),
      .dma1_rd_i (rd_word[0]), .dma1_rvalid_i (rd_valid[0]), .dma1_rready_o (dma1_rready),
      .dma2_rd_i (rd_word[1]), .dma2_rvalid_i (rd_valid[1]), .dma2_rready_o (dma2_rready),
      .dma_wready_i (dma_wready), .dma_wvalid_o (dma_wvalid), .dma_wlast_o (dma_wlast),
      .dma_wdata_o (dma_wdata)
   );

   task automatic abort_run(input string why);
      $display("ERROR at %0t ns: %s", $time, why);
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   always @(negedge clk) begin
      if (dual_cam_accel_top_i.u_assert.fail_count != 0) begin
         abort_run("a protocol assertion on the DUT ports failed");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Register bus
   //////////////////////////////////////////////////////////////////////

   task automatic write_reg(input logic [3:0] word, input logic [31:0] data);
      @(negedge clk);
      reg_we    = 1'b1;
      reg_waddr = {26'd0, word, 2'b00};
      reg_wdata = data;
      @(negedge clk);
      reg_we    = 1'b0;
   endtask

   // Holds re for a few cycles and expects exactly one rvalid
   task automatic read_reg(input logic [3:0] word, output logic [31:0] data);
      int cycles;
      int hold;
      int extra;
      int i;
      cycles = 0;
      extra  = 0;
      hold   = $urandom_range(1, 4);
      @(negedge clk);
      reg_raddr = {26'd0, word, 2'b00};
      reg_re    = 1'b1;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > 8) begin
            abort_run("register read never returned rvalid");
         end
      end while (!reg_rvalid);
      data = reg_rdata;
      for (i = 0; i < hold; i++) begin
         @(negedge clk);
         if (reg_rvalid) extra++;
      end
      reg_re = 1'b0;
      @(negedge clk);
      if (reg_rvalid) extra++;
      check_value("extra rvalid pulses", extra, 0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Streams and frame checking
   //////////////////////////////////////////////////////////////////////

   // Sends random words until one frame of full-keep pixels is taken
   task automatic feed_camera(input int cam);
      int   full_done;
      int   cycles;
      logic pending;
      logic ready;
      full_done = 0;
      cycles    = 0;
      pending   = 1'b0;
      while (full_done < FRAME_PIX) begin
         @(negedge clk);
         cycles++;
         if (cycles > LIMIT) begin
            abort_run($sformatf("camera %0d stream stalled", cam + 1));
         end
         if (!pending && ($urandom_range(0, 2) != 0)) begin
            rd_word[cam].data = $urandom();
            rd_word[cam].keep = ($urandom_range(0, 4) == 0) ? 4'($urandom_range(0, 14))
                                                             : 4'hF;
            pending = 1'b1;
         end
         rd_valid[cam] = pending;
         ready = (cam == 0) ? dma1_rready : dma2_rready;
         // Ready is a flop output, so this word moves on the coming edge
         if (pending && ready) begin
            if (&rd_word[cam].keep) begin
               if (cam == 0) model_q1.push_back(rd_word[cam].data[23:0]);
               else model_q2.push_back(rd_word[cam].data[23:0]);
               accepted[cam]++;
               full_done++;
            end
            pending = 1'b0;
         end
      end
      @(negedge clk);
      rd_valid[cam] = 1'b0;
   endtask

   task automatic expect_idle(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(negedge clk);
         dma_wready = 1'b1;
         check_value("wvalid while writer disarmed", dma_wvalid, 0);
      end
   endtask

   task automatic collect_frame();
      int                   beats;
      int                   cycles;
      dual_cam_pkg::pixel_t p1;
      dual_cam_pkg::pixel_t p2;
      logic [31:0]          exp;
      beats  = 0;
      cycles = 0;
      while (beats < FRAME_PIX) begin
         @(negedge clk);
         cycles++;
         if (cycles > LIMIT) begin
            abort_run("write stream did not finish the frame");
         end
         dma_wready = ($urandom_range(0, 3) != 0);
         if (dma_wvalid && dma_wready) begin
            if (model_q1.size() == 0 || model_q2.size() == 0) begin
               abort_run("write beat appeared before both pixels were sent");
            end
            p1  = model_q1.pop_front();
            p2  = model_q2.pop_front();
            exp = ((beats % `DC_FRAME_WIDTH) < HALF) ? 32'(p1) : 32'(p2);
            check_value($sformatf("wdata of beat %0d", beats), dma_wdata, exp);
            check_value($sformatf("wlast of beat %0d", beats), dma_wlast,
                        32'(beats == FRAME_PIX - 1));
            beats++;
            out_total++;
         end
      end
      @(negedge clk);
      dma_wready = 1'b0;
   endtask

   // Start is still high from the last frame, so only a 0 then 1 may arm
   task automatic run_frame();
      fork
         feed_camera(0);
         feed_camera(1);
         begin
            expect_idle(30);
            write_reg(`DC_REG_START, 32'd0);
            expect_idle(4);
            write_reg(`DC_REG_START, 32'd1);
            collect_frame();
         end
      join
   endtask

   task automatic check_counters();
      logic [31:0] val;
      read_reg(`DC_REG_CNT_IN1, val);
      check_value("camera 1 push counter", val, accepted[0]);
      read_reg(`DC_REG_CNT_IN2, val);
      check_value("camera 2 push counter", val, accepted[1]);
      read_reg(`DC_REG_CNT_OUT, val);
      check_value("output pop counter", val, out_total);
      read_reg(`DC_REG_STATUS, val);
      check_value("status flags", val, 0);
   endtask

   initial begin
      logic [31:0] val;
      void'($urandom(53));
      rst         = 1'b1;
      reg_we      = 1'b0;
      reg_waddr   = '0;
      reg_wdata   = '0;
      reg_re      = 1'b0;
      reg_raddr   = '0;
      rd_word[0]  = '0;
      rd_word[1]  = '0;
      rd_valid[0] = 1'b0;
      rd_valid[1] = 1'b0;
      dma_wready  = 1'b0;
      accepted[0] = 0;
      accepted[1] = 0;
      out_total   = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      read_reg(`DC_REG_ID, val);
      check_value("ID register", val, `DC_ID_VALUE);

      run_frame();
      expect_idle(10);
      check_counters();

      // Second frame after the writer is re-armed
      run_frame();
      expect_idle(10);
      check_counters();

      if (dual_cam_accel_top_i.u_assert.fail_count != 0) begin
         $display("%0d protocol assertions failed",
                  dual_cam_accel_top_i.u_assert.fail_count);
         $display("=== FAIL ===");
         $fatal(1, "assertion failures");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// ==== sources.f ====
+incdir+.
dual_cam_pkg.sv
pix_fifo.sv
dma_stream_rx.sv
dual_cam_merger.sv
dma_frame_writer.sv
ctrl_regs.sv
dual_cam_accel_top.sv
dual_cam_assertions.sv
tb_dual_cam_accel.sv

// ==== Bender.yml ====
package:
  name: dual_cam_accel

sources:
  - include_dirs:
      - .
    files:
      - dual_cam_pkg.sv
      - pix_fifo.sv
      - dma_stream_rx.sv
      - dual_cam_merger.sv
      - dma_frame_writer.sv
      - ctrl_regs.sv
      - dual_cam_accel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dual_cam_assertions.sv
      - tb_dual_cam_accel.sv
